// ==== rtl/tcdm_pkg.sv ====
/*
 * Memory bus widths and vector types of the scratchpad port.
 * Shared by the scratchpad and the source core read master.
 */

package tcdm_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned WORD_W = 32;
  localparam int unsigned WINDOW_W = 2 * WORD_W;

  // scratchpad size in 32-bit words
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // byte address as seen by the streamer
  typedef logic [ADDR_W-1:0] addr_t;

  // one memory or stream item
  typedef logic [WORD_W-1:0] word_t;

  // two consecutive words, lower address in the low half
  typedef logic [WINDOW_W-1:0] window_t;

  // word index into the array
  typedef logic [IDX_W-1:0] word_idx_t;

endpackage : tcdm_pkg

// ==== rtl/streamer_pkg.sv ====
/*
 * Control widths, controller states and queue depths of the source streamer.
 * Used by the address generator, the source core and the top level.
 */

package streamer_pkg;

  localparam int unsigned LEN_W = 16;
  localparam int unsigned STRIDE_W = 32;
  localparam int unsigned OFFS_W = 2;

  // address queue between generator and core
  localparam int unsigned ADDR_FIFO_DEPTH = 2;

  // offset queue, must cover read latency plus outstanding beats
  localparam int unsigned OFFS_FIFO_DEPTH = 4;

  // item count of one run
  typedef logic [LEN_W-1:0] len_t;

  // byte distance between items
  typedef logic [STRIDE_W-1:0] stride_t;

  // byte offset inside a word
  typedef logic [OFFS_W-1:0] offs_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    WORKING = 2'd1,
    DONE    = 2'd2
  } streamer_state_e;

endpackage : streamer_pkg

// ==== rtl/stream_fifo.sv ====
/*
 * Generic valid/ready FIFO built as a circular buffer.
 * Pop side turns valid one cycle after a push, no bypass path.
 */

module stream_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             push_valid_i,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             push_ready_o,
  output logic             pop_valid_o,
  output logic [WIDTH-1:0] pop_data_o,
  input  logic             pop_ready_i,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push, pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign empty_o      = (count_q == '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap at depth
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i; // storage only
    end
  end

endmodule : stream_fifo

// ==== rtl/addr_gen.sv ====
/*
 * Strided byte-address generator for one run of items.
 * Loaded on presample, then steps by the stride on every accepted address.
 */

module addr_gen (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              enable_i,
  input  logic              presample_i,
  input  tcdm_pkg::addr_t   base_addr_i,
  input  streamer_pkg::stride_t stride_i,
  input  streamer_pkg::len_t    len_i,
  output logic              addr_valid_o,
  output tcdm_pkg::addr_t   addr_o,
  input  logic              addr_ready_i,
  output logic              done_o
);

  import tcdm_pkg::*;
  import streamer_pkg::*;

  addr_t addr_q;
  len_t  remaining_q;
  logic  done_q;
  logic  accept;

  assign addr_valid_o = enable_i & (remaining_q != '0);
  assign addr_o       = addr_q;
  assign done_o       = done_q;
  assign accept       = addr_valid_o & addr_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q      <= '0;
      remaining_q <= '0;
      done_q      <= 1'b0;
    end else if (clear_i) begin
      addr_q      <= '0;
      remaining_q <= '0;
      done_q      <= 1'b0;
    end else if (presample_i) begin
      addr_q      <= base_addr_i;
      remaining_q <= len_i;
      done_q      <= (len_i == '0); // empty run ends at once
    end else if (accept) begin
      addr_q      <= addr_q + stride_i;
      remaining_q <= remaining_q - 1'b1;
      if (remaining_q == len_t'(1)) begin
        done_q <= 1'b1; // last address taken
      end
    end
  end

endmodule : addr_gen

// ==== rtl/core_source.sv ====
/*
 * Source core of the streamer: controller, memory read master and realigner.
 * Reads word-aligned windows, shifts them by the queued byte offset and
 * holds the beat under back-pressure, counting beats to detect the end.
 */

module core_source (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  streamer_pkg::len_t   len_i,
  input  logic                 gen_done_i,
  output logic                 gen_enable_o,
  output logic                 gen_presample_o,
  output logic                 gen_clear_o,
  input  logic                 fifo_valid_i,
  input  tcdm_pkg::addr_t      fifo_addr_i,
  input  logic                 fifo_empty_i,
  output logic                 fifo_ready_o,
  output logic                 mem_req_o,
  output tcdm_pkg::word_idx_t  mem_idx_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  tcdm_pkg::window_t    mem_rdata_i,
  output logic                 stream_valid_o,
  input  logic                 stream_ready_i,
  output tcdm_pkg::word_t      stream_data_o,
  output logic                 ready_start_o,
  output logic                 done_o
);

  import tcdm_pkg::*;
  import streamer_pkg::*;

  streamer_state_e state_q, state_d;

  window_t hold_q;
  logic    hold_valid_q;
  window_t window;
  window_t shifted;
  offs_t   offs_push, offs_pop;
  logic    offs_valid;
  logic    granted;
  logic    beat;
  len_t    cnt_q;
  logic    cnt_clr;

  // read master, one request per queued address
  assign mem_req_o    = (state_q != IDLE) & fifo_valid_i & stream_ready_i & ~clear_i;
  assign mem_idx_o    = fifo_addr_i[IDX_W+1:2]; // word-aligned index
  assign granted      = mem_req_o & mem_gnt_i;
  assign fifo_ready_o = granted;
  assign offs_push    = fifo_addr_i[OFFS_W-1:0];

  stream_fifo #(
    .WIDTH ( $bits(offs_t)   ),
    .DEPTH ( OFFS_FIFO_DEPTH )
  ) i_offs_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_valid_i ( granted    ),
    .push_data_i  ( offs_push  ),
    .push_ready_o (            ),
    .pop_valid_o  ( offs_valid ),
    .pop_data_o   ( offs_pop   ),
    .pop_ready_i  ( beat       ),
    .empty_o      (            )
  );

  // realigner on the fresh window or the held one
  assign window         = mem_rvalid_i ? mem_rdata_i : hold_q;
  assign shifted        = window >> {offs_pop, 3'b000};
  assign stream_data_o  = shifted[WORD_W-1:0];
  assign stream_valid_o = (mem_rvalid_i | hold_valid_q) & offs_valid & ~clear_i;
  assign beat           = stream_valid_o & stream_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (beat) begin
      hold_valid_q <= 1'b0;
    end else if (mem_rvalid_i) begin
      hold_valid_q <= 1'b1; // beat stalled by the sink
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rvalid_i) begin
      hold_q <= mem_rdata_i;
    end
  end

  // controller
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d         = state_q;
    ready_start_o   = 1'b0;
    done_o          = 1'b0;
    gen_enable_o    = 1'b0;
    gen_presample_o = 1'b0;
    gen_clear_o     = clear_i;
    cnt_clr         = 1'b0;
    case (state_q)
      IDLE: begin
        ready_start_o = 1'b1;
        if (start_i) begin
          state_d         = WORKING;
          gen_enable_o    = 1'b1;
          gen_presample_o = 1'b1;
        end
      end
      WORKING: begin
        gen_enable_o = 1'b1;
        if (gen_done_i) begin
          state_d = DONE;
        end
      end
      DONE: begin
        gen_enable_o = 1'b1;
        if (fifo_empty_i && (cnt_q == len_i)) begin
          state_d      = IDLE;
          done_o       = 1'b1;
          gen_enable_o = 1'b0;
          gen_clear_o  = 1'b1; // rearm generator
          cnt_clr      = 1'b1;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // beat counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || cnt_clr) begin
      cnt_q <= '0;
    end else if (beat) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule : core_source

// ==== rtl/tcdm_sram.sv ====
/*
 * Single-ported scratchpad with a 64-bit read window and a preload port.
 * Reads return one cycle after the grant; a write blocks the grant.
 */

module tcdm_sram (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  tcdm_pkg::word_idx_t idx_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output tcdm_pkg::window_t   rdata_o,
  input  logic                wr_en_i,
  input  tcdm_pkg::word_idx_t wr_idx_i,
  input  tcdm_pkg::word_t     wr_data_i
);

  import tcdm_pkg::*;

  word_t     mem_q [MEM_WORDS];
  word_idx_t idx_next;
  window_t   rdata_q;
  logic      rvalid_q;
  logic      rd_en;

  assign gnt_o    = ~wr_en_i; // preload owns the port
  assign rd_en    = req_i & gnt_o;
  assign idx_next = idx_i + 1'b1; // wraps at array end
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_idx_i] <= wr_data_i;
    end
    if (rd_en) begin
      rdata_q <= {mem_q[idx_next], mem_q[idx_i]}; // lower word in low half
    end
  end

endmodule : tcdm_sram

// ==== rtl/source_top.sv ====
/*
 * Memory-to-stream source subsystem.
 * Ties the address generator, address queue, source core and scratchpad.
 */

module source_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  start_i,
  input  tcdm_pkg::addr_t       base_addr_i,
  input  streamer_pkg::stride_t stride_i,
  input  streamer_pkg::len_t    len_i,
  output logic                  ready_start_o,
  output logic                  done_o,
  output logic                  stream_valid_o,
  input  logic                  stream_ready_i,
  output tcdm_pkg::word_t       stream_data_o,
  input  logic                  wr_en_i,
  input  tcdm_pkg::word_idx_t   wr_idx_i,
  input  tcdm_pkg::word_t       wr_data_i
);

  import tcdm_pkg::*;
  import streamer_pkg::*;

  logic      gen_enable, gen_presample, gen_clear, gen_done;
  logic      gen_valid, gen_ready;
  addr_t     gen_addr;
  logic      fifo_valid, fifo_ready, fifo_empty;
  addr_t     fifo_addr;
  logic      mem_req, mem_gnt, mem_rvalid;
  word_idx_t mem_idx;
  window_t   mem_rdata;

  addr_gen i_addr_gen (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( gen_clear     ),
    .enable_i     ( gen_enable    ),
    .presample_i  ( gen_presample ),
    .base_addr_i  ( base_addr_i   ),
    .stride_i     ( stride_i      ),
    .len_i        ( len_i         ),
    .addr_valid_o ( gen_valid     ),
    .addr_o       ( gen_addr      ),
    .addr_ready_i ( gen_ready     ),
    .done_o       ( gen_done      )
  );

  stream_fifo #(
    .WIDTH ( $bits(addr_t)   ),
    .DEPTH ( ADDR_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_valid_i ( gen_valid  ),
    .push_data_i  ( gen_addr   ),
    .push_ready_o ( gen_ready  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_data_o   ( fifo_addr  ),
    .pop_ready_i  ( fifo_ready ),
    .empty_o      ( fifo_empty )
  );

  core_source i_core_source (
    .clk_i           ( clk_i          ),
    .rst_ni          ( rst_ni         ),
    .clear_i         ( clear_i        ),
    .start_i         ( start_i        ),
    .len_i           ( len_i          ),
    .gen_done_i      ( gen_done       ),
    .gen_enable_o    ( gen_enable     ),
    .gen_presample_o ( gen_presample  ),
    .gen_clear_o     ( gen_clear      ),
    .fifo_valid_i    ( fifo_valid     ),
    .fifo_addr_i     ( fifo_addr      ),
    .fifo_empty_i    ( fifo_empty     ),
    .fifo_ready_o    ( fifo_ready     ),
    .mem_req_o       ( mem_req        ),
    .mem_idx_o       ( mem_idx        ),
    .mem_gnt_i       ( mem_gnt        ),
    .mem_rvalid_i    ( mem_rvalid     ),
    .mem_rdata_i     ( mem_rdata      ),
    .stream_valid_o  ( stream_valid_o ),
    .stream_ready_i  ( stream_ready_i ),
    .stream_data_o   ( stream_data_o  ),
    .ready_start_o   ( ready_start_o  ),
    .done_o          ( done_o         )
  );

  tcdm_sram i_tcdm_sram (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .req_i     ( mem_req    ),
    .idx_i     ( mem_idx    ),
    .gnt_o     ( mem_gnt    ),
    .rvalid_o  ( mem_rvalid ),
    .rdata_o   ( mem_rdata  ),
    .wr_en_i   ( wr_en_i    ),
    .wr_idx_i  ( wr_idx_i   ),
    .wr_data_i ( wr_data_i  )
  );

endmodule : source_top

// ==== verification/tb_source_top.sv ====
/*
 * Testbench for the memory-to-stream source.
 * Preloads the scratchpad, runs strided streams and checks every beat with assertions.
 */

module tb_source_top;

  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_pkg::*;
  import streamer_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int TOTAL_BEATS = 188;   // sum of all run lengths
  localparam int MARGIN_NS   = 20000; // reset and preload

  logic      clk_i = 1'b0;
  logic      rst_ni, clear_i, start_i;
  addr_t     base_addr_i;
  stride_t   stride_i;
  len_t      len_i;
  logic      ready_start_o, done_o, stream_valid_o, stream_ready_i;
  word_t     stream_data_o;
  logic      wr_en_i;
  word_idx_t wr_idx_i;
  word_t     wr_data_i;

  integer seed = 32'h47ce40a8;
  word_t  mirror [MEM_WORDS];   // copy of scratchpad contents
  word_t  exp_mem [512];        // expected items in order
  int     exp_wr = 0;
  int     exp_rd = 0;
  word_t  exp_head;
  logic   beat_n = 1'b0;
  int     done_cnt = 0;
  int     dones_expected = 0;
  int     preload_cnt = 0;
  logic   preload_on = 1'b0;
  logic   random_ready = 1'b0;
  logic   stall_writes = 1'b0;

  assign exp_head = exp_mem[exp_rd];

  source_top i_source_top (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, expected);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    assert (got === expected) else report_mismatch(name, got, expected);
  endtask

  // item assembled byte by byte from the mirror
  function automatic word_t expected_item(input addr_t addr);
    word_t item;
    addr_t byte_addr;
    for (int b = 0; b < 4; b++) begin
      byte_addr = addr + addr_t'(b);
      item[8*b +: 8] = mirror[byte_addr[IDX_W+1:2]][8*byte_addr[1:0] +: 8];
    end
    return item;
  endfunction

  task automatic start_run(input addr_t base, input stride_t stride, input len_t len);
    for (int k = 0; k < len; k++) begin
      exp_mem[exp_wr] = expected_item(base + addr_t'(k) * stride);
      exp_wr++;
    end
    check_value("ready_start_o", ready_start_o, 1'b1);
    base_addr_i = base;
    stride_i    = stride;
    len_i       = len;
    start_i     = 1'b1;
    @(posedge clk_i);
    #5;
    start_i = 1'b0;
  endtask

  task automatic wait_done();
    do begin
      @(negedge clk_i);
    end while (!done_o);
    dones_expected++;
    @(posedge clk_i);
    #5;
    check_value("done_cnt", done_cnt, dones_expected);
    check_value("ready_start_o", ready_start_o, 1'b1);
  endtask

  // ready pattern, preload writes and stalling writes
  initial begin : cycle_driver
    logic [31:0] rnd;
    stream_ready_i = 1'b1;
    wr_en_i        = 1'b0;
    wr_idx_i       = '0;
    wr_data_i      = '0;
    forever begin
      @(posedge clk_i);
      #5;
      rnd            = $random(seed);
      stream_ready_i = random_ready ? rnd[0] : 1'b1;
      wr_en_i        = 1'b0;
      if (preload_on && preload_cnt < MEM_WORDS) begin
        wr_en_i   = 1'b1;
        wr_idx_i  = word_idx_t'(preload_cnt);
        wr_data_i = $random(seed);
        mirror[wr_idx_i] = wr_data_i;
        preload_cnt++;
      end else if (stall_writes && rnd[1]) begin
        wr_en_i   = 1'b1;
        wr_idx_i  = {2'b11, rnd[8:3]}; // words 192 and up, never read by a run
        wr_data_i = $random(seed);
        mirror[wr_idx_i] = wr_data_i;
      end
    end
  end

  always @(negedge clk_i) begin
    beat_n <= stream_valid_o & stream_ready_i; // transfer at the coming edge
    if (done_o) begin
      done_cnt <= done_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    if (beat_n) begin
      exp_rd <= exp_rd + 1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      (stream_valid_o && stream_ready_i) |-> (exp_rd != exp_wr))
    else abort_run("stream beat with no item expected");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      (stream_valid_o && stream_ready_i) |-> (stream_data_o == exp_head))
    else report_mismatch("stream_data_o", $sampled(stream_data_o), $sampled(exp_head));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      (stream_valid_o && !stream_ready_i && !clear_i) |=>
      (clear_i || (stream_valid_o && $stable(stream_data_o))))
    else abort_run("stream output changed while stalled");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_o |-> (exp_rd == exp_wr))
    else abort_run("done_o raised before every item was transferred");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_o |=> (ready_start_o && !done_o))
    else abort_run("done_o not followed by an idle cycle");

  initial begin : watchdog
    #(CLK_PERIOD * 20 * TOTAL_BEATS + MARGIN_NS);
    abort_run("watchdog timeout, a run did not finish in time");
  end

  initial begin : main_sequence
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    start_i     = 1'b0;
    base_addr_i = '0;
    stride_i    = '0;
    len_i       = '0;
    repeat (3) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    check_value("ready_start_o", ready_start_o, 1'b1);
    check_value("stream_valid_o", stream_valid_o, 1'b0);
    check_value("done_o", done_o, 1'b0);

    preload_on = 1'b1;
    wait (preload_cnt == MEM_WORDS);
    @(posedge clk_i);
    #5;
    preload_on = 1'b0;

    start_run(32'h000, 4, 16); // aligned
    wait_done();
    start_run(32'h021, 4, 8);
    wait_done();
    start_run(32'h042, 4, 8);
    wait_done();
    start_run(32'h063, 4, 8);
    wait_done();
    start_run(32'h008, 12, 10);
    wait_done();
    start_run(32'h005, 7, 20);
    wait_done();

    random_ready = 1'b1;
    start_run(32'h103, 5, 24);
    wait_done();
    start_run(32'h080, 4, 32);
    wait_done();
    stall_writes = 1'b1; // grant stalls on top of back-pressure
    start_run(32'h102, 8, 20);
    wait_done();
    stall_writes = 1'b0;
    random_ready = 1'b0;

    // abort a run, then check that the next one is clean
    start_run(32'h010, 4, 30);
    repeat (6) @(posedge clk_i);
    #5;
    clear_i = 1'b1;
    exp_wr  = exp_rd; // drop the items that will never come
    @(posedge clk_i);
    #5;
    clear_i = 1'b0;
    check_value("ready_start_o", ready_start_o, 1'b1);
    repeat (8) @(posedge clk_i);
    #5;
    check_value("done_cnt", done_cnt, dones_expected);
    start_run(32'h021, 6, 12);
    wait_done();

    repeat (2) @(posedge clk_i);
    #5;
    if (exp_rd == exp_wr && done_cnt == dones_expected) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("items or done pulses left over at the end");
    end
  end

endmodule : tb_source_top

// ==== verilog.f ====
rtl/tcdm_pkg.sv
rtl/streamer_pkg.sv
rtl/stream_fifo.sv
rtl/addr_gen.sv
rtl/core_source.sv
rtl/tcdm_sram.sv
rtl/source_top.sv
verification/tb_source_top.sv

// ==== Bender.yml ====
package:
  name: mem_stream_source

sources:
  - rtl/tcdm_pkg.sv
  - rtl/streamer_pkg.sv
  - rtl/stream_fifo.sv
  - rtl/addr_gen.sv
  - rtl/core_source.sv
  - rtl/tcdm_sram.sv
  - rtl/source_top.sv
  - target: test
    files:
      - verification/tb_source_top.sv
